//--- source/backend_config.svh
// global widths for the pipeline back end, included by the packages and by the RTL that sizes ports
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// integer data width
`define XLEN 64

// register address width, 32 registers
`define REG_AW 5

// data memory depth as log2 of the doubleword count
`define DMEM_AW 8

`endif

//--- source/mem_access_pkg.sv
// data memory access types shared by the pipeline records and the memory stage
`include "backend_config.svh"

package mem_access_pkg;

  // kind of memory access carried by an instruction
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // access size, matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_B = 2'd0,
    MEM_H = 2'd1,
    MEM_W = 2'd2,
    MEM_D = 2'd3
  } mem_size_e;

  // request as it leaves execute
  typedef struct packed {
    mem_op_e          op;
    mem_size_e        size;
    logic             is_unsigned;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } mem_req_t;

endpackage

//--- source/backend_pkg.sv
// pipeline record types passed between execute, memory and writeback
`include "backend_config.svh"

package backend_pkg;
  import mem_access_pkg::*;

  typedef logic [`XLEN-1:0]   xdata_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // which value goes to the register file
  typedef enum logic [1:0] {
    WR_ALU = 2'd0,
    WR_MEM = 2'd1,
    WR_CSR = 2'd2
  } wr_src_e;

  typedef struct packed {
    xdata_t      pc;
    logic [31:0] inst;
    logic        wen;
    reg_addr_t   wdest;
    wr_src_e     wr_src;
    xdata_t      alu_data;
    xdata_t      csr_data;
    mem_req_t    mem;
  } ex_to_mem_t;

  typedef struct packed {
    xdata_t      pc;
    logic [31:0] inst;
    logic        wen;
    reg_addr_t   wdest;
    wr_src_e     wr_src;
    xdata_t      alu_data;
    xdata_t      mem_data;
    xdata_t      csr_data;
  } mem_to_wb_t;

  // bypass record back to decode
  typedef struct packed {
    logic      wen;
    reg_addr_t wdest;
    xdata_t    wdata;
  } wb_forward_t;

  // retired instruction, compared against the trace
  typedef struct packed {
    logic        valid;
    xdata_t      pc;
    logic [31:0] inst;
    logic        wen;
    reg_addr_t   wdest;
    xdata_t      wdata;
  } commit_t;

endpackage

//--- source/pipe_reg.sv
// generic pipeline register holding one record and its valid bit, one per stage boundary
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // no stalls, valid simply follows the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload holds while idle
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

//--- source/data_mem.sv
// doubleword data memory with registered read and per-byte write enables, used by the memory stage
`include "backend_config.svh"

module data_mem (
  input  logic                clk,
  input  logic                en,
  input  logic [`DMEM_AW-1:0] addr,
  input  logic                we,
  input  logic [7:0]          wmask,
  input  logic [`XLEN-1:0]    wdata,
  output logic [`XLEN-1:0]    rdata
);

  localparam int DEPTH = 2 ** `DMEM_AW;
  localparam int LANES = `XLEN / 8;

  logic [`XLEN-1:0] mem [DEPTH];

  // read sees the old word on a same-address write
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
    end
  end

  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int i = 0; i < LANES; i++) begin
        if (wmask[i]) begin
          mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- source/mem_stage.sv
// memory stage: issues the data memory request and aligns returning load data for writeback
`include "backend_config.svh"

module mem_stage
  import mem_access_pkg::*, backend_pkg::*;
(
  input  logic                in_valid,
  input  mem_req_t            req,
  input  logic                rec_valid,
  input  ex_to_mem_t          rec,
  output logic                dmem_en,
  output logic [`DMEM_AW-1:0] dmem_addr,
  output logic                dmem_we,
  output logic [7:0]          dmem_wmask,
  output logic [`XLEN-1:0]    dmem_wdata,
  input  logic [`XLEN-1:0]    dmem_rdata,
  output logic                out_valid,
  output mem_to_wb_t          out
);

  logic [2:0]       offset;
  logic [`XLEN-1:0] lane;
  logic [`XLEN-1:0] load_data;

  // request side, straight from execute
  assign offset     = req.addr[2:0];
  assign dmem_en    = in_valid && (req.op != MEM_NONE);
  assign dmem_we    = in_valid && (req.op == MEM_STORE);
  assign dmem_addr  = req.addr[`DMEM_AW+2:3];

  // alignment assumed, no trap on a misaligned access
  always_comb begin
    unique case (req.size)
      MEM_B: dmem_wmask = 8'h01 << offset;
      MEM_H: dmem_wmask = 8'h03 << offset;
      MEM_W: dmem_wmask = 8'h0f << offset;
      default: dmem_wmask = 8'hff;
    endcase
  end

  // replicate so every lane carries the store data
  always_comb begin
    unique case (req.size)
      MEM_B: dmem_wdata = {8{req.wdata[7:0]}};
      MEM_H: dmem_wdata = {4{req.wdata[15:0]}};
      MEM_W: dmem_wdata = {2{req.wdata[31:0]}};
      default: dmem_wdata = req.wdata;
    endcase
  end

  // return side uses the registered record
  assign lane = dmem_rdata >> {rec.mem.addr[2:0], 3'b000};

  always_comb begin
    unique case (rec.mem.size)
      MEM_B: load_data = rec.mem.is_unsigned ? {{(`XLEN-8){1'b0}}, lane[7:0]}
                                             : {{(`XLEN-8){lane[7]}}, lane[7:0]};
      MEM_H: load_data = rec.mem.is_unsigned ? {{(`XLEN-16){1'b0}}, lane[15:0]}
                                             : {{(`XLEN-16){lane[15]}}, lane[15:0]};
      MEM_W: load_data = rec.mem.is_unsigned ? {{(`XLEN-32){1'b0}}, lane[31:0]}
                                             : {{(`XLEN-32){lane[31]}}, lane[31:0]};
      default: load_data = lane;
    endcase
  end

  assign out_valid = rec_valid;
  assign out = '{
    pc:       rec.pc,
    inst:     rec.inst,
    wen:      rec.wen,
    wdest:    rec.wdest,
    wr_src:   rec.wr_src,
    alu_data: rec.alu_data,
    mem_data: load_data,
    csr_data: rec.csr_data
  };

endmodule

//--- source/wb_stage.sv
// writeback stage: picks the result, drives the register write port, forward and commit records
module wb_stage
  import backend_pkg::*;
(
  input  logic        in_valid,
  input  mem_to_wb_t  in,
  output logic        reg_wen,
  output reg_addr_t   reg_waddr,
  output xdata_t      reg_wdata,
  output wb_forward_t forward,
  output commit_t     commit
);

  always_comb begin
    unique case (in.wr_src)
      WR_MEM: reg_wdata = in.mem_data;
      WR_CSR: reg_wdata = in.csr_data;
      default: reg_wdata = in.alu_data;
    endcase
  end

  // x0 writes dropped here so forward and commit agree with the regfile
  assign reg_wen   = in_valid && in.wen && (in.wdest != '0);
  assign reg_waddr = in.wdest;

  assign forward = '{
    wen:   reg_wen,
    wdest: reg_waddr,
    wdata: reg_wdata
  };

  assign commit = '{
    valid: in_valid,
    pc:    in.pc,
    inst:  in.inst,
    wen:   reg_wen,
    wdest: reg_waddr,
    wdata: reg_wdata
  };

endmodule

//--- source/regfile.sv
// integer register file with one write port and two combinational read ports
module regfile
  import backend_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  xdata_t    wdata,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output xdata_t    rdata1,
  output xdata_t    rdata2
);

  localparam int NREGS = 2 ** $bits(reg_addr_t);

  xdata_t regs [NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // no write-to-read bypass
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- source/backend_top.sv
// back end top: memory stage, writeback stage, data memory and register file behind execute
`include "backend_config.svh"

module backend_top
  import backend_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        ex_valid,
  input  ex_to_mem_t  ex_bus,
  input  reg_addr_t   rs1_addr,
  input  reg_addr_t   rs2_addr,
  output xdata_t      rs1_data,
  output xdata_t      rs2_data,
  output wb_forward_t wb_forward,
  output commit_t     commit
);

  logic                em_valid;
  ex_to_mem_t          em_rec;
  logic                mw_in_valid;
  mem_to_wb_t          mw_in;
  logic                mw_valid;
  mem_to_wb_t          mw_rec;
  logic                dmem_en;
  logic [`DMEM_AW-1:0] dmem_addr;
  logic                dmem_we;
  logic [7:0]          dmem_wmask;
  logic [`XLEN-1:0]    dmem_wdata;
  logic [`XLEN-1:0]    dmem_rdata;
  logic                reg_wen;
  reg_addr_t           reg_waddr;
  xdata_t              reg_wdata;

  pipe_reg #(.payload_t(ex_to_mem_t)) u_ex_mem_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (ex_valid),
    .in_data   (ex_bus),
    .out_valid (em_valid),
    .out_data  (em_rec)
  );

  // memory is addressed from ex_bus, in step with the register above
  mem_stage u_mem_stage (
    .in_valid   (ex_valid),
    .req        (ex_bus.mem),
    .rec_valid  (em_valid),
    .rec        (em_rec),
    .dmem_en    (dmem_en),
    .dmem_addr  (dmem_addr),
    .dmem_we    (dmem_we),
    .dmem_wmask (dmem_wmask),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .out_valid  (mw_in_valid),
    .out        (mw_in)
  );

  data_mem u_data_mem (
    .clk   (clk),
    .en    (dmem_en),
    .addr  (dmem_addr),
    .we    (dmem_we),
    .wmask (dmem_wmask),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata)
  );

  pipe_reg #(.payload_t(mem_to_wb_t)) u_mem_wb_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (mw_in_valid),
    .in_data   (mw_in),
    .out_valid (mw_valid),
    .out_data  (mw_rec)
  );

  wb_stage u_wb_stage (
    .in_valid  (mw_valid),
    .in        (mw_rec),
    .reg_wen   (reg_wen),
    .reg_waddr (reg_waddr),
    .reg_wdata (reg_wdata),
    .forward   (wb_forward),
    .commit    (commit)
  );

  regfile u_regfile (
    .clk    (clk),
    .rst    (rst),
    .wen    (reg_wen),
    .waddr  (reg_waddr),
    .wdata  (reg_wdata),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

endmodule

//--- bench/backend_assert.sv
// protocol assertions bound into backend_top to watch strobes, commits and register writes
module backend_assert
  import backend_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       ex_valid,
  input ex_to_mem_t ex_bus,
  input commit_t    commit,
  input logic       reg_wen
);
  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions
  int fail_count = 0;

  // two edges from strobe to commit in both directions
  a_commit_delay: assert property (@(posedge clk) disable iff (rst)
    ex_valid |-> ##2 commit.valid)
    else begin
      $error("strobe was not followed by a commit two cycles later");
      fail_count++;
    end

  a_commit_source: assert property (@(posedge clk) disable iff (rst)
    commit.valid |-> $past(ex_valid, 2))
    else begin
      $error("commit without a strobe two cycles earlier");
      fail_count++;
    end

  // an instruction aimed at x0 reaches the write port two edges later without a write
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    (ex_valid && ex_bus.wdest == '0) |-> ##2 !reg_wen)
    else begin
      $error("register write addressed x0");
      fail_count++;
    end

  // first reset edge still sees the power-up state
  a_no_commit_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !commit.valid)
    else begin
      $error("commit seen while reset was held");
      fail_count++;
    end

endmodule

bind backend_top backend_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .ex_valid (ex_valid),
  .ex_bus   (ex_bus),
  .commit   (commit),
  .reg_wen  (reg_wen)
);

//--- bench/backend_tb.sv
// testbench that replays the pattern file through backend_top against a byte level reference model
module backend_tb
  import mem_access_pkg::*, backend_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        rst;
  logic        ex_valid;
  ex_to_mem_t  ex_bus;
  reg_addr_t   rs1_addr;
  reg_addr_t   rs2_addr;
  xdata_t      rs1_data;
  xdata_t      rs2_data;
  wb_forward_t wb_forward;
  commit_t     commit;

  // reference state
  logic [7:0] mem_model [2048];
  xdata_t     model_regs [32];
  commit_t    exp_q [$];
  int         due_q [$];
  int         neg_cnt = 0;

  int commit_errs = 0;
  int fwd_errs = 0;
  int reg_errs = 0;
  int other_errs = 0;
  int timeout_errs = 0;

  backend_top uut (
    .clk        (clk),
    .rst        (rst),
    .ex_valid   (ex_valid),
    .ex_bus     (ex_bus),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .wb_forward (wb_forward),
    .commit     (commit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_commit(input commit_t got, input commit_t want);
    if (got !== want) begin
      commit_errs++;
      $display("error at %0t: commit valid %b pc %h inst %h wen %b wdest %0d wdata %h",
               $time, got.valid, got.pc, got.inst, got.wen, got.wdest, got.wdata);
      $display("  expected valid %b pc %h inst %h wen %b wdest %0d wdata %h",
               want.valid, want.pc, want.inst, want.wen, want.wdest, want.wdata);
    end
  endtask

  task automatic check_forward(input wb_forward_t got, input wb_forward_t want);
    if (got !== want) begin
      fwd_errs++;
      $display("error at %0t: forward wen %b wdest %0d wdata %h",
               $time, got.wen, got.wdest, got.wdata);
      $display("  expected wen %b wdest %0d wdata %h", want.wen, want.wdest, want.wdata);
    end
  endtask

  task automatic check_reg(input reg_addr_t idx, input xdata_t got, input xdata_t want);
    if (got !== want) begin
      reg_errs++;
      $display("error at %0t: x%0d reads %h, expected %h", $time, idx, got, want);
    end
  endtask

  // little endian gather and extension from the top byte of the access
  function automatic xdata_t model_load(input xdata_t addr, input logic [1:0] size,
                                        input logic uns);
    int         n;
    logic [10:0] a;
    logic [7:0]  top;
    xdata_t      v;
    n = 1 << size;
    v = '0;
    for (int i = 0; i < n; i++) begin
      a = addr[10:0] + 11'(i);
      v[8*i +: 8] = mem_model[a];
    end
    top = v[8*(n-1) +: 8];
    if (!uns && top[7]) begin
      for (int i = n; i < 8; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  task automatic model_store(input xdata_t addr, input logic [1:0] size, input xdata_t data);
    int          n;
    logic [10:0] a;
    n = 1 << size;
    for (int i = 0; i < n; i++) begin
      a = addr[10:0] + 11'(i);
      mem_model[a] = data[8*i +: 8];
    end
  endtask

  task automatic print_counts();
    $display("errors: commit %0d, forward %0d, register %0d, other %0d, timeout %0d, assertion %0d",
             commit_errs, fwd_errs, reg_errs, other_errs, timeout_errs,
             uut.u_assert.fail_count);
  endtask

  task automatic finish_run();
    int total;
    total = commit_errs + fwd_errs + reg_errs + other_errs + timeout_errs
            + uut.u_assert.fail_count;
    print_counts();
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // idle until every queued commit has been seen
  task automatic wait_commits_done();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      ex_valid <= 1'b0;
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeout_errs++;
      $display("timeout: the commit for pc %h never arrived within 20 cycles", exp_q[0].pc);
    end
  endtask

  task automatic issue(input string kind, input xdata_t pc, input logic [31:0] inst,
                       input reg_addr_t wdest, input logic [1:0] size, input logic uns,
                       input xdata_t addr, input xdata_t data);
    ex_to_mem_t rec;
    commit_t    want;
    int         gap;
    rec = '0;
    rec.pc = pc;
    rec.inst = inst;
    rec.wdest = wdest;
    rec.wr_src = WR_ALU;
    rec.mem.op = MEM_NONE;
    rec.mem.size = mem_size_e'(size);
    rec.mem.is_unsigned = uns;
    rec.mem.addr = addr;
    want = '0;
    want.valid = 1'b1;
    want.pc = pc;
    want.inst = inst;
    want.wdest = wdest;
    if (kind == "alu") begin
      rec.wen = 1'b1;
      rec.alu_data = data;
      rec.csr_data = ~data;
      want.wdata = data;
    end else if (kind == "csr") begin
      rec.wen = 1'b1;
      rec.wr_src = WR_CSR;
      rec.csr_data = data;
      rec.alu_data = ~data;
      want.wdata = data;
    end else if (kind == "load") begin
      rec.wen = 1'b1;
      rec.wr_src = WR_MEM;
      rec.mem.op = MEM_LOAD;
      rec.alu_data = addr;
      want.wdata = model_load(addr, size, uns);
    end else begin
      // store commits the address from the ALU with no register write
      rec.mem.op = MEM_STORE;
      rec.mem.wdata = data;
      rec.alu_data = addr;
      want.wdata = addr;
      model_store(addr, size, data);
    end
    want.wen = rec.wen && (wdest != '0);
    if (want.wen) begin
      model_regs[wdest] = want.wdata;
    end
    @(posedge clk);
    ex_valid <= 1'b1;
    ex_bus <= rec;
    exp_q.push_back(want);
    due_q.push_back(neg_cnt + 3);
    // loads right behind stores go back to back
    gap = (kind == "store") ? 0 : int'($urandom % 3);
    repeat (gap) begin
      @(posedge clk);
      ex_valid <= 1'b0;
    end
  endtask

  // second port reads the next register so the two ports see different addresses
  task automatic read_reg_check(input reg_addr_t idx, input xdata_t file_val);
    reg_addr_t other;
    other = reg_addr_t'(idx + 1);
    wait_commits_done();
    @(posedge clk);
    ex_valid <= 1'b0;
    rs1_addr <= idx;
    rs2_addr <= other;
    @(negedge clk);
    check_reg(idx, rs1_data, model_regs[idx]);
    check_reg(other, rs2_data, model_regs[other]);
    if (model_regs[idx] !== file_val) begin
      other_errs++;
      $display("pattern file expects x%0d to hold %h but the reference model holds %h",
               idx, file_val, model_regs[idx]);
    end
  endtask

  // commits are compared mid cycle and in order
  always @(negedge clk) begin
    commit_t     want;
    wb_forward_t fwd_want;
    int          due;
    neg_cnt++;
    if (!rst && commit.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        commit_errs++;
        $display("error at %0t: commit for pc %h with nothing outstanding", $time, commit.pc);
      end else begin
        want = exp_q.pop_front();
        due = due_q.pop_front();
        if (neg_cnt != due) begin
          commit_errs++;
          $display("error at %0t: commit for pc %h in cycle %0d, expected cycle %0d",
                   $time, want.pc, neg_cnt, due);
        end
        check_commit(commit, want);
        fwd_want.wen = want.wen;
        fwd_want.wdest = want.wdest;
        fwd_want.wdata = want.wdata;
        check_forward(wb_forward, fwd_want);
      end
    end else if (!rst && wb_forward.wen !== 1'b0) begin
      fwd_errs++;
      $display("error at %0t: forward wen is %b with no commit", $time, wb_forward.wen);
    end
  end

  initial begin
    int          fd;
    int          n;
    string       kind;
    string       rest;
    logic [63:0] f_pc;
    logic [63:0] f_inst;
    logic [63:0] f_wdest;
    logic [63:0] f_size;
    logic [63:0] f_uns;
    logic [63:0] f_addr;
    logic [63:0] f_data;
    void'($urandom(74385));
    rst <= 1'b1;
    ex_valid <= 1'b0;
    ex_bus <= '0;
    rs1_addr <= '0;
    rs2_addr <= '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 2048; i++) begin
      mem_model[i] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (commit.valid !== 1'b0) begin
      commit_errs++;
      $display("error at %0t: commit.valid is %b after reset", $time, commit.valid);
    end
    if (wb_forward.wen !== 1'b0) begin
      fwd_errs++;
      $display("error at %0t: forward wen is %b after reset", $time, wb_forward.wen);
    end
    for (int i = 0; i < 32; i++) begin
      read_reg_check(reg_addr_t'(i), '0);
    end
    fd = $fopen("bench/backend_patterns.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open bench/backend_patterns.txt");
    end else begin
      while (timeout_errs == 0 && $fscanf(fd, "%s", kind) == 1) begin
        if (kind.getc(0) == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h",
                      f_pc, f_inst, f_wdest, f_size, f_uns, f_addr, f_data);
          if (n != 7) begin
            other_errs++;
            $display("pattern line of kind %s has %0d fields instead of 7", kind, n);
          end else if (kind == "read") begin
            read_reg_check(f_wdest[4:0], f_data);
          end else if (kind == "alu" || kind == "csr" || kind == "load" || kind == "store") begin
            issue(kind, f_pc, f_inst[31:0], f_wdest[4:0], f_size[1:0], f_uns[0], f_addr, f_data);
          end else begin
            other_errs++;
            $display("pattern line has unknown kind %s", kind);
          end
        end
      end
      $fclose(fd);
      if (timeout_errs == 0) begin
        wait_commits_done();
      end
    end
    finish_run();
  end

endmodule

//--- all.f
+incdir+source
source/mem_access_pkg.sv
source/backend_pkg.sv
source/pipe_reg.sv
source/data_mem.sv
source/mem_stage.sv
source/wb_stage.sv
source/regfile.sv
source/backend_top.sv
bench/backend_assert.sv
bench/backend_tb.sv

//--- Makefile
BIN := obj_dir/Vbackend_tb

$(BIN): all.f $(shell grep -v '^+' all.f) source/backend_config.svh
	verilator --binary --assert --timescale 1ns/100ps --top-module backend_tb -f all.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- bench/backend_patterns.txt
# kind pc inst wdest size unsigned addr data, all numbers in hex
# alu csr store take data as the source value, read expects wdest to hold data
alu   1000 00500093 01 0 0 0000 0000000000000005
alu   1004 fff00113 02 0 0 0000 ffffffffffffffff
csr   1008 c00021f3 03 0 0 0000 0000000012345678
alu   100c 00700013 00 0 0 0000 0000000000000007
read  0000 00000000 01 0 0 0000 0000000000000005
read  0000 00000000 02 0 0 0000 ffffffffffffffff
read  0000 00000000 03 0 0 0000 0000000012345678
read  0000 00000000 00 0 0 0000 0000000000000000
store 1010 04503023 0a 3 0 0040 1122334455667788
load  1014 04003403 08 3 0 0040 0000000000000000
store 1018 045000a3 0a 0 0 0041 00000000000000a5
load  101c 04100483 09 0 0 0041 0000000000000000
load  1020 04003583 0b 3 0 0040 0000000000000000
load  1024 04104603 0c 0 1 0041 0000000000000000
store 1028 04501323 0a 1 0 0046 0000000000008001
load  102c 04601683 0d 1 0 0046 0000000000000000
load  1030 04605703 0e 1 1 0046 0000000000000000
store 1034 04502223 0a 2 0 0044 0000000089abcdef
load  1038 04402783 0f 2 0 0044 0000000000000000
load  103c 04406803 10 2 1 0044 0000000000000000
load  1040 04002883 11 2 0 0040 0000000000000000
read  0000 00000000 08 0 0 0000 1122334455667788
read  0000 00000000 09 0 0 0000 ffffffffffffffa5
read  0000 00000000 0a 0 0 0000 0000000000000000
read  0000 00000000 0b 0 0 0000 112233445566a588
read  0000 00000000 0c 0 0 0000 00000000000000a5
read  0000 00000000 0d 0 0 0000 ffffffffffff8001
read  0000 00000000 0e 0 0 0000 0000000000008001
read  0000 00000000 0f 0 0 0000 ffffffff89abcdef
read  0000 00000000 10 0 0 0000 0000000089abcdef
read  0000 00000000 11 0 0 0000 000000005566a588
